// File: all.f
+incdir+include
hdl/redmule_pkg.sv
hdl/redmule_engine.sv
hdl/redmule_w_loader.sv
hdl/redmule_xy_loader.sv
hdl/redmule_z_writer.sv
hdl/redmule_mem_arbiter.sv
hdl/redmule_ctrl.sv
hdl/redmule_top.sv
verification/redmule_properties.sv
verification/redmule_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and scan the log for the failure line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module redmule_tb -f all.f \
  -o redmule_sim &&
  ./obj_dir/redmule_sim > sim.log 2>&1 &&
  cat sim.log &&
  ! grep -q "Verification failed" sim.log &&
  echo "run.sh: simulation ok" ||
  { cat sim.log 2>/dev/null; echo "run.sh: simulation reported an error"; exit 1; }

// File: verification/redmule_tb.sv
`timescale 1ns/100ps
`include "redmule_cfg.svh"

module redmule_tb
  import redmule_pkg::*;
();

  localparam int NUM_JOBS = 5;
  localparam int MAX_M    = 8;

  logic                            clk_i;
  logic                            reset_i;
  logic                            cfg_req_i;
  logic                            cfg_we_i;
  reg_offset_e                     cfg_addr_i;
  logic [`REDMULE_CFG_DATA_W-1:0]  cfg_wdata_i;
  logic [`REDMULE_CFG_DATA_W-1:0]  cfg_rdata_o;
  logic                            mem_req_o;
  logic                            mem_we_o;
  addr_t                           mem_addr_o;
  row_t                            mem_wdata_o;
  logic                            mem_gnt_i;
  row_t                            mem_rdata_i;
  logic                            busy_o;
  logic                            evt_o;

  integer  seed;
  int      errors = 0;
  int      checks = 0;
  int      err_before = 0;
  int      tests_run = 0;
  int      tests_failed = 0;
  int      cycle_cnt = 0;
  int      cycle_limit = 0;
  int      evt_cnt = 0;
  bit      bp_mode;
  addr_t   cur_z_base;
  int      cur_m;

  // Sparse word memory behind the DUT
  row_t    mem [addr_t];

  // Job table
  int      job_m [NUM_JOBS];
  addr_t   job_x [NUM_JOBS];
  addr_t   job_w [NUM_JOBS];
  addr_t   job_y [NUM_JOBS];
  addr_t   job_z [NUM_JOBS];
  bit      job_extreme [NUM_JOBS];
  bit      job_bp [NUM_JOBS];

  // Operands of the running job
  row_t    x_rows [MAX_M];
  row_t    y_rows [MAX_M];
  tile_t   w_tile;

  redmule_top redmule_top_inst (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .mem_req_o   ( mem_req_o   ),
    .mem_we_o    ( mem_we_o    ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_wdata_o ( mem_wdata_o ),
    .mem_gnt_i   ( mem_gnt_i   ),
    .mem_rdata_i ( mem_rdata_i ),
    .busy_o      ( busy_o      ),
    .evt_o       ( evt_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Unwritten words still differ in every address bit
  function automatic row_t background(input addr_t a);
    return {a ^ 16'h0f0f, a + 16'h1111, ~a, a};
  endfunction

  function automatic row_t read_word(input addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return background(a);
  endfunction

  // Z[j] = Y[j] + sum over k of X[k] * W[k][j] modulo 2^16
  function automatic row_t expected_z(input row_t x, input row_t y, input tile_t w);
    row_t    z;
    longint  sum;
    for (int j = 0; j < `REDMULE_ROW_LEN; j++) begin
      sum = y[j];
      for (int k = 0; k < `REDMULE_ROW_LEN; k++) begin
        sum = sum + longint'(x[k]) * longint'(w[k][j]);
      end
      z[j] = sum[15:0];
    end
    return z;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic cfg_write(input reg_offset_e addr, input logic [31:0] data);
    cfg_req_i   = 1'b1;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    step();
    cfg_req_i   = 1'b0;
    cfg_we_i    = 1'b0;
  endtask

  // Read data is registered and sampled one edge after the request
  task automatic cfg_read(input reg_offset_e addr, output logic [31:0] data);
    cfg_req_i  = 1'b1;
    cfg_we_i   = 1'b0;
    cfg_addr_i = addr;
    step();
    cfg_req_i  = 1'b0;
    data       = cfg_rdata_o;
  endtask

  task automatic check_row(input string name, input row_t got, input row_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == err_before) begin
      $display("Test %0d (%s): ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d (%s): %0d errors", tests_run, name, errors - err_before);
    end
    err_before = errors;
  endtask

  task automatic set_job(input int idx, input int m, input addr_t x, input addr_t w,
                         input addr_t y, input addr_t z, input bit extreme, input bit bp);
    job_m[idx]       = m;
    job_x[idx]       = x;
    job_w[idx]       = w;
    job_y[idx]       = y;
    job_z[idx]       = z;
    job_extreme[idx] = extreme;
    job_bp[idx]      = bp;
  endtask

  task automatic load_job_table();
    // M, X, W, Y and Z bases, extreme values, grant back-pressure
    set_job(0, 1, 16'h0100, 16'h0140, 16'h0180, 16'h01c0, 1'b0, 1'b0);
    set_job(1, 8, 16'h1000, 16'h1040, 16'h1080, 16'h10c0, 1'b0, 1'b1);
    set_job(2, 4, 16'h2000, 16'h2040, 16'h2080, 16'h20c0, 1'b1, 1'b0);
    set_job(3, 6, 16'h3000, 16'h3040, 16'h3080, 16'h30c0, 1'b1, 1'b1);
    set_job(4, 3, 16'hf000, 16'hf010, 16'hf020, 16'hf030, 1'b0, 1'b0);
  endtask

  task automatic fill_row(input bit extreme, output row_t r);
    integer       rnd;
    logic [15:0]  corner [4];
    corner[0] = 16'h7fff;
    corner[1] = 16'h8000;
    corner[2] = 16'hffff;
    corner[3] = 16'h8001;
    for (int n = 0; n < `REDMULE_ROW_LEN; n++) begin
      rnd = $random(seed);
      r[n] = extreme ? corner[rnd[1:0]] : rnd[15:0];
    end
  endtask

  task automatic test_registers();
    logic [31:0] data;
    check_bit("busy_o", busy_o, 1'b0);
    cfg_write(REG_X_ADDR, 32'h0000_1234);
    cfg_write(REG_W_ADDR, 32'h0000_5678);
    cfg_write(REG_Y_ADDR, 32'hdead_9abc);
    cfg_write(REG_Z_ADDR, 32'h0000_def0);
    cfg_write(REG_M_SIZE, 32'h0000_0307);
    // Only the address and size fields are stored
    cfg_read(REG_M_SIZE, data);
    check_reg("m_size", data, 32'h0000_0007);
    cfg_read(REG_X_ADDR, data);
    check_reg("x_addr", data, 32'h0000_1234);
    cfg_read(REG_W_ADDR, data);
    check_reg("w_addr", data, 32'h0000_5678);
    cfg_read(REG_Y_ADDR, data);
    check_reg("y_addr", data, 32'h0000_9abc);
    cfg_read(REG_Z_ADDR, data);
    check_reg("z_addr", data, 32'h0000_def0);
    cfg_read(REG_STATUS, data);
    check_reg("status", data, 32'h0);
    cfg_read(REG_TRIGGER, data);
    check_reg("trigger", data, 32'h0);
    finish_test("register readback");
  endtask

  task automatic test_zero_size();
    int           evt_start;
    logic [31:0]  data;
    cfg_write(REG_M_SIZE, 32'd0);
    evt_start = evt_cnt;
    cfg_write(REG_TRIGGER, 32'd1);
    check_bit("busy_o", busy_o, 1'b0);
    repeat (10) step();
    check_count("evt_count", evt_cnt - evt_start, 0);
    cfg_read(REG_STATUS, data);
    check_reg("status", data, 32'h0);
    finish_test("trigger with M_SIZE zero");
  endtask

  task automatic run_job(input int idx);
    int           m;
    int           evt_start;
    addr_t        a;
    row_t         r;
    logic [31:0]  data;
    m = job_m[idx];
    for (int k = 0; k < `REDMULE_ROW_LEN; k++) begin
      fill_row(job_extreme[idx], r);
      w_tile[k] = r;
      a = job_w[idx] + addr_t'(k);
      mem[a] = r;
    end
    for (int i = 0; i < m; i++) begin
      fill_row(job_extreme[idx], x_rows[i]);
      fill_row(job_extreme[idx], y_rows[i]);
      a = job_x[idx] + addr_t'(i);
      mem[a] = x_rows[i];
      a = job_y[idx] + addr_t'(i);
      mem[a] = y_rows[i];
    end
    cur_z_base = job_z[idx];
    cur_m      = m;
    cfg_write(REG_X_ADDR, 32'(job_x[idx]));
    cfg_write(REG_W_ADDR, 32'(job_w[idx]));
    cfg_write(REG_Y_ADDR, 32'(job_y[idx]));
    cfg_write(REG_Z_ADDR, 32'(job_z[idx]));
    cfg_write(REG_M_SIZE, 32'(m));
    bp_mode   = job_bp[idx];
    evt_start = evt_cnt;
    cfg_write(REG_TRIGGER, 32'd1);
    check_bit("busy_o", busy_o, 1'b1);
    // A trigger during the job must not start a second one
    cfg_write(REG_TRIGGER, 32'd1);
    // The W load is still running, so the status bit is set
    cfg_read(REG_STATUS, data);
    check_reg("status", data, 32'h1);
    while (evt_cnt == evt_start) begin
      step();
    end
    bp_mode = 1'b0;
    repeat (4) step();
    check_count("evt_count", evt_cnt - evt_start, 1);
    check_bit("busy_o", busy_o, 1'b0);
    for (int i = 0; i < m; i++) begin
      a = job_z[idx] + addr_t'(i);
      check_row($sformatf("z_row[%0d]", i), read_word(a),
                expected_z(x_rows[i], y_rows[i], w_tile));
      a = job_x[idx] + addr_t'(i);
      check_row($sformatf("x_row[%0d]", i), read_word(a), x_rows[i]);
      a = job_y[idx] + addr_t'(i);
      check_row($sformatf("y_row[%0d]", i), read_word(a), y_rows[i]);
    end
    for (int k = 0; k < `REDMULE_ROW_LEN; k++) begin
      a = job_w[idx] + addr_t'(k);
      check_row($sformatf("w_row[%0d]", k), read_word(a), w_tile[k]);
    end
    cur_m = 0;
    finish_test($sformatf("job %0d, M=%0d, back-pressure %0b", idx, m, job_bp[idx]));
  endtask

  // Memory port model samples the bus late in the cycle and answers after the edge
  initial begin : memory_model
    logic    txn_req;
    logic    txn_we;
    logic    txn_gnt;
    addr_t   txn_addr;
    row_t    txn_wdata;
    bit      bp_now;
    integer  rnd;
    txn_req     = 1'b0;
    txn_we      = 1'b0;
    txn_gnt     = 1'b0;
    txn_addr    = '0;
    txn_wdata   = '0;
    bp_now      = 1'b0;
    mem_gnt_i   = 1'b0;
    mem_rdata_i = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (txn_req && txn_gnt) begin
        if (txn_we) begin
          if (cur_m == 0 || int'(addr_t'(txn_addr - cur_z_base)) >= cur_m) begin
            errors++;
            $display("Error at %0t: write to %h outside the Z region", $time, txn_addr);
          end
          mem[txn_addr] = txn_wdata;
        end else begin
          mem_rdata_i = read_word(txn_addr);
        end
      end
      if (bp_now) begin
        rnd       = $random(seed);
        mem_gnt_i = rnd[0];
      end else begin
        mem_gnt_i = 1'b1;
      end
      #7;
      txn_req   = mem_req_o;
      txn_we    = mem_we_o;
      txn_gnt   = mem_gnt_i;
      txn_addr  = mem_addr_o;
      txn_wdata = mem_wdata_o;
      bp_now    = bp_mode;
    end
  end

  // Event counter and cycle limit
  initial begin : watchdog
    do begin
      @(posedge clk_i);
      #8;
      cycle_cnt++;
      if (evt_o) begin
        evt_cnt++;
      end
    end while (cycle_cnt < cycle_limit);
    $display("Timeout: the run did not end within %0d cycles", cycle_limit);
    $display("Verification failed");
    $finish;
  end

  initial begin : main
    seed        = 32'h875f762d;
    reset_i     = 1'b1;
    cfg_req_i   = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = REG_X_ADDR;
    cfg_wdata_i = '0;
    bp_mode     = 1'b0;
    cur_z_base  = '0;
    cur_m       = 0;
    load_job_table();
    // Margin for reset and register tests plus each job's own budget
    cycle_limit = 100;
    for (int i = 0; i < NUM_JOBS; i++) begin
      cycle_limit = cycle_limit + 8 * (2 * job_m[i] + 4) + 50;
    end
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    test_registers();
    test_zero_size();
    for (int i = 0; i < NUM_JOBS; i++) begin
      run_job(i);
    end
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : redmule_tb

// File: verification/redmule_properties.sv
`timescale 1ns/100ps

module redmule_properties
  import redmule_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   busy_i,
  input  logic   evt_i,
  input  logic   mem_req_i,
  input  logic   mem_we_i,
  input  addr_t  mem_addr_i,
  input  row_t   mem_wdata_i,
  input  logic   mem_gnt_i
);

  // End of job is a single-cycle pulse
  evt_single_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    evt_i |=> !evt_i)
    else $error("evt_o stayed high for two cycles");

  // A stalled request keeps its address, direction and write data
  req_held_until_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_req_i && !mem_gnt_i) |=> (mem_req_i && $stable(mem_addr_i) && $stable(mem_we_i)
                                   && (!mem_we_i || $stable(mem_wdata_i))))
    else $error("memory request changed before it was granted");

  reset_quiet: assert property (@(posedge clk_i)
    $past(reset_i) |-> (!busy_i && !mem_req_i && !evt_i))
    else $error("busy, event or memory request active during reset");

  evt_after_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    evt_i |-> $past(busy_i))
    else $error("evt_o without a running job");

endmodule : redmule_properties

bind redmule_top redmule_properties redmule_properties_inst (
  .clk_i       ( clk_i       ),
  .reset_i     ( reset_i     ),
  .busy_i      ( busy_o      ),
  .evt_i       ( evt_o       ),
  .mem_req_i   ( mem_req_o   ),
  .mem_we_i    ( mem_we_o    ),
  .mem_addr_i  ( mem_addr_o  ),
  .mem_wdata_i ( mem_wdata_o ),
  .mem_gnt_i   ( mem_gnt_i   )
);

// File: hdl/redmule_top.sv
`timescale 1ns/100ps
`include "redmule_cfg.svh"

module redmule_top (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // Host register port
  input  logic                            cfg_req_i,
  input  logic                            cfg_we_i,
  input  redmule_pkg::reg_offset_e        cfg_addr_i,
  input  logic [`REDMULE_CFG_DATA_W-1:0]  cfg_wdata_i,
  output logic [`REDMULE_CFG_DATA_W-1:0]  cfg_rdata_o,
  // Shared memory port
  output logic                            mem_req_o,
  output logic                            mem_we_o,
  output redmule_pkg::addr_t              mem_addr_o,
  output redmule_pkg::row_t               mem_wdata_o,
  input  logic                            mem_gnt_i,
  input  redmule_pkg::row_t               mem_rdata_i,
  output logic                            busy_o,
  output logic                            evt_o
);

  redmule_pkg::addr_t   x_addr, w_addr, y_addr, z_addr;
  redmule_pkg::msize_t  m_size;
  logic                 w_start, w_loaded, xy_start, z_done;

  redmule_pkg::tile_t   w_tile;
  redmule_pkg::row_t    x_row, y_row, z_row, z_mem_wdata;
  logic                 xy_valid, xy_ready, z_valid, z_ready;

  // Per-peer memory requests
  logic                 w_mem_req, w_gnt, w_rvalid;
  logic                 xy_mem_req, xy_gnt, xy_rvalid;
  logic                 z_mem_req, z_gnt;
  redmule_pkg::addr_t   w_mem_addr, xy_mem_addr, z_mem_addr;

  redmule_ctrl i_ctrl (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .x_addr_o    ( x_addr      ),
    .w_addr_o    ( w_addr      ),
    .y_addr_o    ( y_addr      ),
    .z_addr_o    ( z_addr      ),
    .m_size_o    ( m_size      ),
    .w_start_o   ( w_start     ),
    .w_loaded_i  ( w_loaded    ),
    .xy_start_o  ( xy_start    ),
    .z_done_i    ( z_done      ),
    .busy_o      ( busy_o      ),
    .evt_o       ( evt_o       )
  );

  redmule_w_loader i_w_loader (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .start_i     ( w_start     ),
    .base_addr_i ( w_addr      ),
    .req_o       ( w_mem_req   ),
    .addr_o      ( w_mem_addr  ),
    .gnt_i       ( w_gnt       ),
    .rvalid_i    ( w_rvalid    ),
    .rdata_i     ( mem_rdata_i ),
    .w_tile_o    ( w_tile      ),
    .loaded_o    ( w_loaded    )
  );

  redmule_xy_loader i_xy_loader (
    .clk_i    ( clk_i       ),
    .reset_i  ( reset_i     ),
    .start_i  ( xy_start    ),
    .x_base_i ( x_addr      ),
    .y_base_i ( y_addr      ),
    .m_size_i ( m_size      ),
    .req_o    ( xy_mem_req  ),
    .addr_o   ( xy_mem_addr ),
    .gnt_i    ( xy_gnt      ),
    .rvalid_i ( xy_rvalid   ),
    .rdata_i  ( mem_rdata_i ),
    .x_row_o  ( x_row       ),
    .y_row_o  ( y_row       ),
    .valid_o  ( xy_valid    ),
    .ready_i  ( xy_ready    )
  );

  redmule_engine i_engine (
    .clk_i    ( clk_i    ),
    .reset_i  ( reset_i  ),
    .x_row_i  ( x_row    ),
    .y_row_i  ( y_row    ),
    .w_tile_i ( w_tile   ),
    .valid_i  ( xy_valid ),
    .ready_o  ( xy_ready ),
    .z_row_o  ( z_row    ),
    .valid_o  ( z_valid  ),
    .ready_i  ( z_ready  )
  );

  redmule_z_writer i_z_writer (
    .clk_i    ( clk_i       ),
    .reset_i  ( reset_i     ),
    .z_base_i ( z_addr      ),
    .m_size_i ( m_size      ),
    .start_i  ( xy_start    ),
    .z_row_i  ( z_row       ),
    .valid_i  ( z_valid     ),
    .ready_o  ( z_ready     ),
    .req_o    ( z_mem_req   ),
    .addr_o   ( z_mem_addr  ),
    .wdata_o  ( z_mem_wdata ),
    .gnt_i    ( z_gnt       ),
    .done_o   ( z_done      )
  );

  redmule_mem_arbiter i_mem_arbiter (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .z_req_i     ( z_mem_req   ),
    .z_addr_i    ( z_mem_addr  ),
    .z_wdata_i   ( z_mem_wdata ),
    .z_gnt_o     ( z_gnt       ),
    .w_req_i     ( w_mem_req   ),
    .w_addr_i    ( w_mem_addr  ),
    .w_gnt_o     ( w_gnt       ),
    .w_rvalid_o  ( w_rvalid    ),
    .xy_req_i    ( xy_mem_req  ),
    .xy_addr_i   ( xy_mem_addr ),
    .xy_gnt_o    ( xy_gnt      ),
    .xy_rvalid_o ( xy_rvalid   ),
    .mem_req_o   ( mem_req_o   ),
    .mem_we_o    ( mem_we_o    ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_wdata_o ( mem_wdata_o ),
    .mem_gnt_i   ( mem_gnt_i   )
  );

endmodule : redmule_top

// File: hdl/redmule_ctrl.sv
`timescale 1ns/100ps
`include "redmule_cfg.svh"

module redmule_ctrl
  import redmule_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            cfg_req_i,
  input  logic                            cfg_we_i,
  input  reg_offset_e                     cfg_addr_i,
  input  logic [`REDMULE_CFG_DATA_W-1:0]  cfg_wdata_i,
  output logic [`REDMULE_CFG_DATA_W-1:0]  cfg_rdata_o,
  output addr_t                           x_addr_o,
  output addr_t                           w_addr_o,
  output addr_t                           y_addr_o,
  output addr_t                           z_addr_o,
  output msize_t                          m_size_o,
  output logic                            w_start_o,
  input  logic                            w_loaded_i,
  output logic                            xy_start_o,
  input  logic                            z_done_i,
  output logic                            busy_o,
  output logic                            evt_o
);

  job_state_e                       state_q, state_d;
  addr_t                            x_addr_q, w_addr_q, y_addr_q, z_addr_q;
  msize_t                           m_size_q;
  logic [`REDMULE_CFG_DATA_W-1:0]   rdata_d;
  logic                             busy;
  logic                             cfg_write;
  logic                             trigger_ok;

  // DONE is the end-of-job cycle, busy already reads low there
  assign busy       = (state_q == LOAD_W) || (state_q == RUN);
  // Job registers are frozen while a job runs
  assign cfg_write  = cfg_req_i && cfg_we_i && !busy;
  assign trigger_ok = cfg_write && (cfg_addr_i == REG_TRIGGER) && (m_size_q != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      x_addr_q <= '0;
      w_addr_q <= '0;
      y_addr_q <= '0;
      z_addr_q <= '0;
      m_size_q <= '0;
    end else if (cfg_write) begin
      case (cfg_addr_i)
        REG_X_ADDR: x_addr_q <= cfg_wdata_i[`REDMULE_ADDR_W-1:0];
        REG_W_ADDR: w_addr_q <= cfg_wdata_i[`REDMULE_ADDR_W-1:0];
        REG_Y_ADDR: y_addr_q <= cfg_wdata_i[`REDMULE_ADDR_W-1:0];
        REG_Z_ADDR: z_addr_q <= cfg_wdata_i[`REDMULE_ADDR_W-1:0];
        REG_M_SIZE: m_size_q <= cfg_wdata_i[`REDMULE_MSIZE_W-1:0];
        default: ;
      endcase
    end
  end

  // Readback mux, trigger and unused offsets read as zero
  always_comb begin
    rdata_d = '0;
    case (cfg_addr_i)
      REG_X_ADDR: rdata_d[`REDMULE_ADDR_W-1:0]  = x_addr_q;
      REG_W_ADDR: rdata_d[`REDMULE_ADDR_W-1:0]  = w_addr_q;
      REG_Y_ADDR: rdata_d[`REDMULE_ADDR_W-1:0]  = y_addr_q;
      REG_Z_ADDR: rdata_d[`REDMULE_ADDR_W-1:0]  = z_addr_q;
      REG_M_SIZE: rdata_d[`REDMULE_MSIZE_W-1:0] = m_size_q;
      REG_STATUS: rdata_d[0]                    = busy;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_rdata_o <= '0;
    end else if (cfg_req_i && !cfg_we_i) begin
      cfg_rdata_o <= rdata_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE: begin
        state_d = trigger_ok ? LOAD_W : IDLE;
      end
      LOAD_W: begin
        if (w_loaded_i) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (z_done_i) begin
          state_d = DONE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // The W loader drops loaded on the same edge that enters LOAD_W
  assign w_start_o  = trigger_ok;
  assign xy_start_o = (state_q == LOAD_W) && w_loaded_i;

  assign x_addr_o = x_addr_q;
  assign w_addr_o = w_addr_q;
  assign y_addr_o = y_addr_q;
  assign z_addr_o = z_addr_q;
  assign m_size_o = m_size_q;
  assign busy_o   = busy;
  assign evt_o    = (state_q == DONE);

endmodule : redmule_ctrl

// File: hdl/redmule_mem_arbiter.sv
`timescale 1ns/100ps

module redmule_mem_arbiter
  import redmule_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   z_req_i,
  input  addr_t  z_addr_i,
  input  row_t   z_wdata_i,
  output logic   z_gnt_o,
  input  logic   w_req_i,
  input  addr_t  w_addr_i,
  output logic   w_gnt_o,
  output logic   w_rvalid_o,
  input  logic   xy_req_i,
  input  addr_t  xy_addr_i,
  output logic   xy_gnt_o,
  output logic   xy_rvalid_o,
  output logic   mem_req_o,
  output logic   mem_we_o,
  output addr_t  mem_addr_o,
  output row_t   mem_wdata_o,
  input  logic   mem_gnt_i
);

  mem_owner_e  sel, owner_q;
  logic        lock_q, rd_pending_q;
  logic        granted;

  // A stalled request keeps the port until it is granted
  always_comb begin
    if (lock_q) begin
      sel = owner_q;
    end else if (z_req_i) begin
      sel = OWN_Z;
    end else if (w_req_i) begin
      sel = OWN_W;
    end else begin
      sel = OWN_XY;
    end
  end

  always_comb begin
    case (sel)
      OWN_Z: begin
        mem_req_o  = z_req_i;
        mem_addr_o = z_addr_i;
      end
      OWN_W: begin
        mem_req_o  = w_req_i;
        mem_addr_o = w_addr_i;
      end
      default: begin
        mem_req_o  = xy_req_i;
        mem_addr_o = xy_addr_i;
      end
    endcase
  end

  assign mem_we_o    = mem_req_o && (sel == OWN_Z);
  assign mem_wdata_o = z_wdata_i;
  assign granted     = mem_req_o && mem_gnt_i;

  assign z_gnt_o  = granted && (sel == OWN_Z);
  assign w_gnt_o  = granted && (sel == OWN_W);
  assign xy_gnt_o = granted && (sel == OWN_XY);

  // owner_q doubles as the owner of last cycle's read
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q       <= 1'b0;
      rd_pending_q <= 1'b0;
      owner_q      <= OWN_Z;
    end else begin
      lock_q       <= mem_req_o && !mem_gnt_i;
      rd_pending_q <= granted && !mem_we_o;
      owner_q      <= sel;
    end
  end

  assign w_rvalid_o  = rd_pending_q && (owner_q == OWN_W);
  assign xy_rvalid_o = rd_pending_q && (owner_q == OWN_XY);

endmodule : redmule_mem_arbiter

// File: hdl/redmule_z_writer.sv
`timescale 1ns/100ps

module redmule_z_writer
  import redmule_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  addr_t   z_base_i,
  input  msize_t  m_size_i,
  input  logic    start_i,
  input  row_t    z_row_i,
  input  logic    valid_i,
  output logic    ready_o,
  output logic    req_o,
  output addr_t   addr_o,
  output row_t    wdata_o,
  input  logic    gnt_i,
  output logic    done_o
);

  msize_t  row_cnt_q, next_row;
  logic    full_q;
  logic    write_done;
  row_t    hold_q;

  assign next_row   = row_cnt_q + 1'b1;
  assign write_done = full_q && gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q    <= 1'b0;
      row_cnt_q <= '0;
    end else begin
      if (start_i) begin
        row_cnt_q <= '0;
      end else if (write_done) begin
        row_cnt_q <= next_row;
      end
      // Holding register empties on grant and refills from the engine
      if (write_done) begin
        full_q <= 1'b0;
      end else if (valid_i && !full_q) begin
        full_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && !full_q) begin
      hold_q <= z_row_i;
    end
  end

  assign ready_o = !full_q;
  assign req_o   = full_q;
  assign addr_o  = z_base_i + addr_t'(row_cnt_q);
  assign wdata_o = hold_q;
  // Grant of the last row ends the job
  assign done_o  = write_done && (next_row == m_size_i);

endmodule : redmule_z_writer

// File: hdl/redmule_xy_loader.sv
`timescale 1ns/100ps

module redmule_xy_loader
  import redmule_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    start_i,
  input  addr_t   x_base_i,
  input  addr_t   y_base_i,
  input  msize_t  m_size_i,
  output logic    req_o,
  output addr_t   addr_o,
  input  logic    gnt_i,
  input  logic    rvalid_i,
  input  row_t    rdata_i,
  output row_t    x_row_o,
  output row_t    y_row_o,
  output logic    valid_o,
  input  logic    ready_i
);

  msize_t  row_cnt_q, next_row;
  logic    req_q, sel_y_q, rx_y_q, valid_q;
  row_t    x_row_q, y_row_q;

  assign next_row = row_cnt_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      row_cnt_q <= '0;
      req_q     <= 1'b0;
      sel_y_q   <= 1'b0;
      rx_y_q    <= 1'b0;
      valid_q   <= 1'b0;
    end else if (start_i) begin
      row_cnt_q <= '0;
      req_q     <= 1'b1;
      sel_y_q   <= 1'b0;
      rx_y_q    <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      // X then Y, the Y read may go out before X data returns
      if (req_q && gnt_i) begin
        sel_y_q <= !sel_y_q;
        if (sel_y_q) begin
          req_q <= 1'b0;
        end
      end
      if (rvalid_i) begin
        rx_y_q <= !rx_y_q;
        if (rx_y_q) begin
          valid_q <= 1'b1;
        end
      end
      // Next row is fetched only once the engine took this pair
      if (valid_q && ready_i) begin
        valid_q <= 1'b0;
        if (next_row != m_size_i) begin
          row_cnt_q <= next_row;
          req_q     <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvalid_i && !rx_y_q) begin
      x_row_q <= rdata_i;
    end
    if (rvalid_i && rx_y_q) begin
      y_row_q <= rdata_i;
    end
  end

  assign req_o   = req_q;
  assign addr_o  = (sel_y_q ? y_base_i : x_base_i) + addr_t'(row_cnt_q);
  assign x_row_o = x_row_q;
  assign y_row_o = y_row_q;
  assign valid_o = valid_q;

endmodule : redmule_xy_loader

// File: hdl/redmule_w_loader.sv
`timescale 1ns/100ps
`include "redmule_cfg.svh"

module redmule_w_loader
  import redmule_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   start_i,
  input  addr_t  base_addr_i,
  output logic   req_o,
  output addr_t  addr_o,
  input  logic   gnt_i,
  input  logic   rvalid_i,
  input  row_t   rdata_i,
  output tile_t  w_tile_o,
  output logic   loaded_o
);

  localparam int unsigned CNT_W = $clog2(`REDMULE_ROW_LEN);

  logic [CNT_W-1:0]  rd_cnt_q, rx_cnt_q;
  logic              req_q, loaded_q;
  tile_t             tile_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q    <= 1'b0;
      rd_cnt_q <= '0;
      rx_cnt_q <= '0;
      loaded_q <= 1'b0;
    end else if (start_i) begin
      req_q    <= 1'b1;
      rd_cnt_q <= '0;
      rx_cnt_q <= '0;
      loaded_q <= 1'b0;
    end else begin
      // Issue side, stop after the last row is granted
      if (req_q && gnt_i) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
        if (rd_cnt_q == CNT_W'(`REDMULE_ROW_LEN - 1)) begin
          req_q <= 1'b0;
        end
      end
      if (rvalid_i) begin
        rx_cnt_q <= rx_cnt_q + 1'b1;
        if (rx_cnt_q == CNT_W'(`REDMULE_ROW_LEN - 1)) begin
          loaded_q <= 1'b1;
        end
      end
    end
  end

  // Rows land in arrival order
  always_ff @(posedge clk_i) begin
    if (rvalid_i) begin
      tile_q[rx_cnt_q] <= rdata_i;
    end
  end

  assign req_o    = req_q;
  assign addr_o   = base_addr_i + addr_t'(rd_cnt_q);
  assign w_tile_o = tile_q;
  assign loaded_o = loaded_q;

endmodule : redmule_w_loader

// File: hdl/redmule_engine.sv
`timescale 1ns/100ps
`include "redmule_cfg.svh"

module redmule_engine
  import redmule_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  row_t   x_row_i,
  input  row_t   y_row_i,
  input  tile_t  w_tile_i,
  input  logic   valid_i,
  output logic   ready_o,
  output row_t   z_row_o,
  output logic   valid_o,
  input  logic   ready_i
);

  row_t   z_row_d, z_row_q;
  elem_t  acc;
  logic   valid_q;
  logic   accept;

  // Z[j] = Y[j] + sum over k of X[k] * W[k][j], wrapping at 16 bits
  always_comb begin
    z_row_d = '0;
    acc     = '0;
    for (int j = 0; j < `REDMULE_ROW_LEN; j++) begin
      acc = y_row_i[j];
      for (int k = 0; k < `REDMULE_ROW_LEN; k++) begin
        acc = acc + x_row_i[k] * w_tile_i[k][j];
      end
      z_row_d[j] = acc;
    end
  end

  // Output register can refill in the cycle it drains
  assign ready_o = !valid_q || ready_i;
  assign accept  = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      z_row_q <= z_row_d;
    end
  end

  assign z_row_o = z_row_q;
  assign valid_o = valid_q;

endmodule : redmule_engine

// File: hdl/redmule_pkg.sv
`include "redmule_cfg.svh"

package redmule_pkg;

  typedef logic signed [`REDMULE_ELEM_W-1:0] elem_t;

  // Element n sits at bits 16n upward
  typedef elem_t [`REDMULE_ROW_LEN-1:0] row_t;

  // Entry k is row k of W
  typedef row_t [`REDMULE_ROW_LEN-1:0] tile_t;

  typedef logic [`REDMULE_ADDR_W-1:0] addr_t;
  typedef logic [`REDMULE_MSIZE_W-1:0] msize_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD_W,
    RUN,
    DONE
  } job_state_e;

  typedef enum logic [$clog2(`REDMULE_NUM_REGS)-1:0] {
    REG_X_ADDR  = 0,
    REG_W_ADDR  = 1,
    REG_Y_ADDR  = 2,
    REG_Z_ADDR  = 3,
    REG_M_SIZE  = 4,
    REG_TRIGGER = 5,
    REG_STATUS  = 6
  } reg_offset_e;

  // Highest priority first
  typedef enum logic [1:0] {
    OWN_Z,
    OWN_W,
    OWN_XY
  } mem_owner_e;

endpackage

// File: include/redmule_cfg.svh
`ifndef REDMULE_CFG_SVH
`define REDMULE_CFG_SVH

// Element and tile geometry
`define REDMULE_ELEM_W 16
`define REDMULE_ROW_LEN 4

// One memory word carries one full row
`define REDMULE_WORD_W (`REDMULE_ELEM_W * `REDMULE_ROW_LEN)

// Word addresses and row counts
`define REDMULE_ADDR_W 16
`define REDMULE_MSIZE_W 8

// Peripheral side
`define REDMULE_CFG_DATA_W 32
`define REDMULE_NUM_REGS 7

`endif
